/* ice51_lite.f */
hw/ice51_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/code_port_arbiter.sv
hw/cpu_control.sv
hw/cpu_datapath.sv
hw/ice51_lite.sv
bench/tb_clk_gen.sv
bench/ice51_lite_sva.sv
bench/tb_ice51_lite.sv

/* bench/tb_ice51_lite.sv */
`timescale 1ns/1ps

module tb_ice51_lite;

   localparam int BIT_CYCLES     = ice51_pkg::UART_SAMPLE + 1;
   localparam int LOAD_CYCLES    = ice51_pkg::CODE_DEPTH * 10 * BIT_CYCLES;
   localparam int TIMEOUT_CYCLES = LOAD_CYCLES + 62_400;  // reset, program, two frames
   localparam int PROG_LEN       = 38;

   logic                  clk;
   logic                  nrst;
   logic                  uart_rx = 1'b1;
   logic                  uart_tx;
   logic                  code_wr;
   ice51_pkg::code_addr_t code_addr;
   ice51_pkg::byte_t      code_wdata;
   ice51_pkg::byte_t      code_rdata = '0;
   logic                  data_wr;
   ice51_pkg::data_addr_t data_addr;
   ice51_pkg::byte_t      data_wdata;
   ice51_pkg::byte_t      data_rdata = '0;

   ice51_pkg::byte_t      code_mem [ice51_pkg::CODE_DEPTH];
   ice51_pkg::byte_t      data_mem [ice51_pkg::CODE_DEPTH];
   ice51_pkg::byte_t      prog     [ice51_pkg::CODE_DEPTH];
   ice51_pkg::byte_t      rd_code;
   ice51_pkg::byte_t      rd_data;
   ice51_pkg::byte_t      frames [$];

   integer                seed;
   ice51_pkg::byte_t      start_a;
   ice51_pkg::byte_t      step_b;
   ice51_pkg::byte_t      loop_n;
   ice51_pkg::byte_t      exp_result;
   logic                  exp_carry;
   int                    mismatch_count   = 0;
   int                    fail_count       = 0;
   int                    load_count       = 0;
   int                    data_wr_count    = 0;
   int                    frame_cnt        = 0;
   int                    cycle_cnt        = 0;
   logic                  first_fetch_seen = 1'b0;
   logic                  frames_done      = 1'b0;

   tb_clk_gen tb_clk_gen_inst (.o_clk(clk), .o_nrst(nrst));

   ice51_lite ice51_lite_inst (
      .i_clk(clk), .i_nrst(nrst), .i_uart_rx(uart_rx), .o_uart_tx(uart_tx),
      .o_code_wr(code_wr), .o_code_addr(code_addr), .o_code_data(code_wdata),
      .i_code_data(code_rdata), .o_data_wr(data_wr), .o_data_addr(data_addr),
      .o_data_data(data_wdata), .i_data_data(data_rdata)
   );

   ////////////////////////////////////////
   // memory models

   // synchronous read, old data on a write, output 1 ns after the edge
   always @(posedge clk) begin
      rd_code = code_mem[code_addr];
      rd_data = data_mem[data_addr];
      if (code_wr)
         code_mem[code_addr] = code_wdata;
      if (data_wr)
         data_mem[data_addr] = data_wdata;
      #1;
      code_rdata = rd_code;
      data_rdata = rd_data;
   end

   ////////////////////////////////////////
   // checks and reference

   task automatic check_byte(input string name, input ice51_pkg::byte_t exp_val,
                             input ice51_pkg::byte_t act_val);
      if (act_val !== exp_val) begin
         $display("Mismatch %s: expected %h, actual %h", name, exp_val, act_val);
         mismatch_count++;
      end
   endtask

   task automatic check_code_addr(input string name, input ice51_pkg::code_addr_t exp_val,
                                  input ice51_pkg::code_addr_t act_val);
      if (act_val !== exp_val) begin
         $display("Mismatch %s: expected %h, actual %h", name, exp_val, act_val);
         mismatch_count++;
      end
   endtask

   task automatic check_bit(input string name, input logic exp_val, input logic act_val);
      if (act_val !== exp_val) begin
         $display("Mismatch %s: expected %b, actual %b", name, exp_val, act_val);
         mismatch_count++;
      end
   endtask

   task automatic check_idle_outputs(input string phase);
      check_bit({phase, " o_uart_tx"}, 1'b1, uart_tx);
      check_bit({phase, " o_code_wr"}, 1'b0, code_wr);
      check_bit({phase, " o_data_wr"}, 1'b0, data_wr);
   endtask

   // a plus n times b, carry of the last add in bit 8
   function automatic logic [8:0] ref_sum(input ice51_pkg::byte_t a,
                                          input ice51_pkg::byte_t b,
                                          input ice51_pkg::byte_t n);
      logic [8:0]       sum;
      ice51_pkg::byte_t acc;
      int               k;
      acc = a;
      sum = {1'b0, a};
      for (k = 0; k < n; k++) begin
         sum = {1'b0, acc} + {1'b0, b};
         acc = sum[7:0];
      end
      return sum;
   endfunction

   task automatic build_program;
      ice51_pkg::byte_t body [PROG_LEN];
      int               k;
      body = '{
         ice51_pkg::MOV_A_IMM, start_a,           // 00
         ice51_pkg::MOV_RN_A | 8'h01,             // 02 r1 keeps the sum
         ice51_pkg::MOV_RN_IMM | 8'h02, loop_n,   // 03 r2 counts down
         ice51_pkg::MOV_A_RN | 8'h01,             // 05 loop top
         ice51_pkg::ADD_A_IMM, step_b,            // 06
         ice51_pkg::MOV_RN_A | 8'h01,             // 08
         ice51_pkg::DEC_RN | 8'h02,               // 09
         ice51_pkg::MOV_A_RN | 8'h02,             // 0a
         ice51_pkg::JNZ, 8'hF8,                   // 0b back to 05
         ice51_pkg::MOV_A_RN | 8'h01,             // 0d
         ice51_pkg::MOV_DIR_A, 8'h10,             // 0e
         ice51_pkg::MOV_DPTR_IMM, 8'h02, 8'h01,   // 10
         ice51_pkg::MOVX_DPTR_A,                  // 13 first send
         ice51_pkg::MOV_DPTR_IMM, 8'h02, 8'h00,   // 14
         ice51_pkg::MOVX_A_DPTR,                  // 17 busy poll
         ice51_pkg::JNZ, 8'hFD,                   // 18 back to 17
         ice51_pkg::MOV_A_IMM, 8'h4E,             // 1a
         ice51_pkg::JNC, 8'h02,                   // 1c skip to 20
         ice51_pkg::MOV_A_IMM, 8'h43,             // 1e
         ice51_pkg::MOV_DPTR_IMM, 8'h02, 8'h01,   // 20
         ice51_pkg::MOVX_DPTR_A,                  // 23 second send
         ice51_pkg::SJMP, 8'hFE                   // 24 park
      };
      for (k = 0; k < ice51_pkg::CODE_DEPTH; k++)
         prog[k] = (k < PROG_LEN) ? body[k] : 8'h00;  // nop padding
   endtask

   // one 8N1 frame, each step ends 1 ns after a rising edge
   task automatic send_byte(input ice51_pkg::byte_t value);
      logic [9:0] frame;
      int         k;
      frame = {1'b1, value, 1'b0};
      for (k = 0; k < 10; k++) begin
         uart_rx = frame[k];
         repeat (BIT_CYCLES) @(posedge clk);
         #1;
      end
   endtask

   task automatic end_run;
      int sva_fails;
      sva_fails = ice51_lite_inst.ice51_lite_sva_inst.assert_fail_count;
      $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
               mismatch_count, fail_count, sva_fails);
      if (mismatch_count == 0 && fail_count == 0 && sva_fails == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   endtask

   ////////////////////////////////////////
   // monitors

   initial begin : reset_checks
      @(negedge clk);
      while (!nrst) begin
         check_idle_outputs("reset");
         @(negedge clk);
      end
      check_idle_outputs("after reset");
   end

   // loader writes, then the core's first fetch
   always @(negedge clk) begin
      if (nrst && load_count < ice51_pkg::CODE_DEPTH) begin
         if (code_wr) begin
            check_code_addr("load address", ice51_pkg::code_addr_t'(load_count), code_addr);
            check_byte("load data", prog[load_count], code_wdata);
            load_count++;
         end
      end else if (nrst) begin
         if (!first_fetch_seen)
            check_code_addr("first fetch address", '0, code_addr);
         first_fetch_seen = 1'b1;
         if (code_wr) begin
            $display("Error: code write at %h after loading finished", code_addr);
            fail_count++;
         end
      end
   end

   always @(negedge clk) begin
      if (nrst && data_wr) begin
         if (data_wr_count == 0) begin
            check_byte("store address", 8'h10, data_addr[7:0]);
            check_bit("store address bit 8", 1'b0, data_addr[8]);
            check_byte("stored result", exp_result, data_wdata);
         end else begin
            $display("Error: unexpected extra data write at %h", data_addr);
            fail_count++;
         end
         data_wr_count++;
      end
   end

   initial begin : uart_monitor
      ice51_pkg::byte_t frame;
      int               k;
      forever begin
         @(negedge clk);
         if (nrst && !uart_tx) begin
            repeat (BIT_CYCLES / 2) @(negedge clk);  // middle of start bit
            if (uart_tx) begin
               $display("Error: start bit on o_uart_tx ended early");
               fail_count++;
            end else begin
               for (k = 0; k < 8; k++) begin
                  repeat (BIT_CYCLES) @(negedge clk);
                  frame[k] = uart_tx;  // lsb first
               end
               repeat (BIT_CYCLES) @(negedge clk);
               if (!uart_tx) begin
                  $display("Error: stop bit missing on o_uart_tx");
                  fail_count++;
               end
               frames.push_back(frame);
               frame_cnt++;
            end
         end
      end
   end

   initial begin : frame_compare
      wait (frame_cnt >= 1);
      check_byte("first frame", exp_result, frames[0]);
      wait (frame_cnt >= 2);
      check_byte("second frame", exp_carry ? 8'h43 : 8'h4E, frames[1]);
      frames_done = 1'b1;
   end

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt == TIMEOUT_CYCLES) begin
         $display("Error: run stopped after %0d cycles without both frames", cycle_cnt);
         fail_count++;
         end_run();
      end
   end

   ////////////////////////////////////////
   // main sequence

   initial begin : main_seq
      logic [8:0] ref_out;
      int         k;
      seed    = 32'hea98;
      start_a = ice51_pkg::byte_t'($random(seed));
      step_b  = ice51_pkg::byte_t'($random(seed));
      loop_n  = ice51_pkg::byte_t'(1 + ($unsigned($random(seed)) % 15));
      ref_out    = ref_sum(start_a, step_b, loop_n);
      exp_result = ref_out[7:0];
      exp_carry  = ref_out[8];
      for (k = 0; k < ice51_pkg::CODE_DEPTH; k++) begin
         code_mem[k] = ice51_pkg::byte_t'(k ^ (k >> 4));
         data_mem[k] = ice51_pkg::byte_t'(~k ^ (k >> 3));
      end
      build_program();
      $display("a=%h b=%h n=%0d, expecting %h carry %b",
               start_a, step_b, loop_n, exp_result, exp_carry);
      @(posedge nrst);
      @(posedge clk);
      #1;
      for (k = 0; k < ice51_pkg::CODE_DEPTH; k++)
         send_byte(prog[k]);
      wait (frames_done);
      if (!first_fetch_seen) begin
         $display("Error: core never fetched after loading");
         fail_count++;
      end
      if (data_wr_count == 0) begin
         $display("Error: result never stored to data address 0x10");
         fail_count++;
      end
      end_run();
   end

endmodule

/* bench/ice51_lite_sva.sv */
`timescale 1ns/1ps

module ice51_lite_sva (
   input logic i_clk,
   input logic i_nrst,
   input logic i_run,
   input logic i_uart_tx,
   input logic i_code_wr,
   input logic i_data_wr
);

   int assert_fail_count = 0;

   ////////////////////////////////////////
   // code port ownership

   // core only reads once it owns the port
   a_core_no_code_wr: assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_run |-> !i_code_wr)
      else begin
         $error("code write while the core owns the code port");
         assert_fail_count++;
      end

   ////////////////////////////////////////
   // idle outputs

   a_tx_idle_in_reset: assert property (@(posedge i_clk) !i_nrst |-> i_uart_tx)
      else begin
         $error("serial line low during reset");
         assert_fail_count++;
      end

   a_no_data_wr_loading: assert property (@(posedge i_clk) disable iff (!i_nrst)
      !i_run |-> !i_data_wr)
      else begin
         $error("data write while the loader owns the code port");
         assert_fail_count++;
      end

endmodule

bind ice51_lite ice51_lite_sva ice51_lite_sva_inst (
   .i_clk(i_clk), .i_nrst(i_nrst), .i_run(run), .i_uart_tx(o_uart_tx),
   .i_code_wr(o_code_wr), .i_data_wr(o_data_wr)
);

/* bench/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
   output logic o_clk,
   output logic o_nrst
);

   initial begin
      o_clk = 1'b0;
      forever #5 o_clk = ~o_clk;  // 10 ns period
   end

   // reset held for 10 cycles, released just after an edge
   initial begin
      o_nrst = 1'b0;
      repeat (10) @(posedge o_clk);
      #1 o_nrst = 1'b1;
   end

endmodule

/* hw/ice51_lite.sv */
`timescale 1ns/1ps

module ice51_lite (
   input  logic                  i_clk,
   input  logic                  i_nrst,
   input  logic                  i_uart_rx,
   output logic                  o_uart_tx,
   output logic                  o_code_wr,
   output ice51_pkg::code_addr_t o_code_addr,
   output ice51_pkg::byte_t      o_code_data,
   input  ice51_pkg::byte_t      i_code_data,
   output logic                  o_data_wr,
   output ice51_pkg::data_addr_t o_data_addr,
   output ice51_pkg::byte_t      o_data_data,
   input  ice51_pkg::byte_t      i_data_data
);

   logic                   rx_valid;
   ice51_pkg::byte_t       rx_byte;
   logic                   run;
   ice51_pkg::code_req_t   core_req;
   ice51_pkg::exec_cmd_t   cmd;
   ice51_pkg::core_flags_t flags;
   logic                   tx_start;
   ice51_pkg::byte_t       tx_byte;
   logic                   tx_busy;

   ////////////////////////////////////////
   // boot loader path

   uart_rx uart_rx_inst (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_uart_rx(i_uart_rx),
      .o_rx_valid(rx_valid), .o_rx_byte(rx_byte)
   );

   code_port_arbiter code_port_arbiter_inst (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_rx_valid(rx_valid), .i_rx_byte(rx_byte),
      .i_core_req(core_req), .o_code_wr(o_code_wr), .o_code_addr(o_code_addr),
      .o_code_data(o_code_data), .o_run(run)
   );

   ////////////////////////////////////////
   // core and transmitter

   cpu_control cpu_control_inst (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_run(run), .i_code_data(i_code_data),
      .i_data_data(i_data_data), .i_flags(flags), .o_core_req(core_req), .o_cmd(cmd),
      .o_data_wr(o_data_wr), .o_data_addr(o_data_addr), .o_data_data(o_data_data)
   );

   cpu_datapath cpu_datapath_inst (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_cmd(cmd), .i_tx_busy(tx_busy),
      .o_flags(flags), .o_tx_start(tx_start), .o_tx_byte(tx_byte)
   );

   uart_tx uart_tx_inst (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_tx_start(tx_start), .i_tx_byte(tx_byte),
      .o_uart_tx(o_uart_tx), .o_tx_busy(tx_busy)
   );

endmodule

/* hw/cpu_datapath.sv */
`timescale 1ns/1ps

module cpu_datapath (
   input  logic                    i_clk,
   input  logic                    i_nrst,
   input  ice51_pkg::exec_cmd_t    i_cmd,
   input  logic                    i_tx_busy,
   output ice51_pkg::core_flags_t  o_flags,
   output logic                    o_tx_start,
   output ice51_pkg::byte_t        o_tx_byte
);

   ice51_pkg::byte_t       acc;
   ice51_pkg::byte_t [7:0] r_bank;
   logic                   carry;
   ice51_pkg::dptr_t       dptr;

   ice51_pkg::byte_t       op;
   ice51_pkg::reg_idx_t    r_idx;
   ice51_pkg::byte_t       r_sel;
   ice51_pkg::byte_t       add_rhs;
   logic [8:0]             add_sum;
   logic                   op_add;
   logic                   op_rn_imm;
   logic                   op_a_rn;
   logic                   op_rn_a;
   logic                   op_add_rn;
   logic                   op_dec_rn;
   logic                   stat_rd;

   ////////////////////////////////////////
   // decode

   assign op        = i_cmd.opcode;
   assign r_idx     = op[2:0];
   assign r_sel     = r_bank[r_idx];
   assign op_rn_imm = (op[7:3] == ice51_pkg::MOV_RN_IMM[7:3]);
   assign op_a_rn   = (op[7:3] == ice51_pkg::MOV_A_RN[7:3]);
   assign op_rn_a   = (op[7:3] == ice51_pkg::MOV_RN_A[7:3]);
   assign op_add_rn = (op[7:3] == ice51_pkg::ADD_A_RN[7:3]);
   assign op_dec_rn = (op[7:3] == ice51_pkg::DEC_RN[7:3]);
   assign op_add    = op_add_rn || (op == ice51_pkg::ADD_A_IMM) || (op == ice51_pkg::INC_A);

   assign add_rhs = (op == ice51_pkg::ADD_A_IMM) ? i_cmd.opnd1 :
                    op_add_rn                    ? r_sel : 8'd1;  // inc a
   assign add_sum = {1'b0, acc} + {1'b0, add_rhs};

   assign stat_rd = (op == ice51_pkg::MOVX_A_DPTR) && (dptr == ice51_pkg::UART_STAT_ADDR);

   ////////////////////////////////////////
   // accumulator and carry

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         acc   <= '0;
         carry <= 1'b0;
      end else if (i_cmd.exec) begin
         if (op == ice51_pkg::MOV_A_IMM)
            acc <= i_cmd.opnd1;
         else if (op == ice51_pkg::MOV_A_DIR)
            acc <= i_cmd.data_rd;
         else if (op_a_rn)
            acc <= r_sel;
         else if (op_add)
            acc <= add_sum[7:0];
         else if (stat_rd)
            acc <= {7'd0, i_tx_busy};  // busy flag in bit 0

         if (op_add)
            carry <= add_sum[8];
         else if (op == ice51_pkg::CLR_C)
            carry <= 1'b0;
      end
   end

   // register bank
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst)
         r_bank <= '0;
      else if (i_cmd.exec) begin
         if (op_rn_imm)
            r_bank[r_idx] <= i_cmd.opnd1;
         else if (op_rn_a)
            r_bank[r_idx] <= acc;
         else if (op_dec_rn)
            r_bank[r_idx] <= r_sel - 8'd1;  // wraps
      end
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst)
         dptr <= '0;
      else if (i_cmd.exec && op == ice51_pkg::MOV_DPTR_IMM)
         dptr <= {i_cmd.opnd1, i_cmd.opnd2};
   end

   ////////////////////////////////////////
   // flags and transmitter

   assign o_flags.acc_zero = (acc == 8'd0);
   assign o_flags.carry    = carry;
   assign o_flags.acc      = acc;

   // a start while busy is dropped by the framer
   assign o_tx_start = i_cmd.exec && (op == ice51_pkg::MOVX_DPTR_A) &&
                       (dptr == ice51_pkg::UART_TX_ADDR);
   assign o_tx_byte  = acc;

endmodule

/* hw/cpu_control.sv */
`timescale 1ns/1ps

module cpu_control (
   input  logic                    i_clk,
   input  logic                    i_nrst,
   input  logic                    i_run,
   input  ice51_pkg::byte_t        i_code_data,
   input  ice51_pkg::byte_t        i_data_data,
   input  ice51_pkg::core_flags_t  i_flags,
   output ice51_pkg::code_req_t    o_core_req,
   output ice51_pkg::exec_cmd_t    o_cmd,
   output logic                    o_data_wr,
   output ice51_pkg::data_addr_t   o_data_addr,
   output ice51_pkg::byte_t        o_data_data
);

   ice51_pkg::cpu_state_e state;
   ice51_pkg::cpu_state_e state_nxt;
   ice51_pkg::code_addr_t pc;
   ice51_pkg::code_addr_t br_off;
   ice51_pkg::byte_t      op_q;
   ice51_pkg::byte_t      opnd1_q;
   ice51_pkg::byte_t      opnd2_q;
   logic                  pc_inc;
   logic                  br_take;

   // instruction length in bytes
   function automatic logic [1:0] instr_len(input ice51_pkg::byte_t op);
      logic two_byte;
      two_byte = (op == ice51_pkg::MOV_A_IMM) || (op == ice51_pkg::MOV_A_DIR) ||
                 (op == ice51_pkg::MOV_DIR_A) || (op == ice51_pkg::ADD_A_IMM) ||
                 (op[7:3] == ice51_pkg::MOV_RN_IMM[7:3]) ||
                 (op == ice51_pkg::SJMP) || (op == ice51_pkg::JZ) ||
                 (op == ice51_pkg::JNZ) || (op == ice51_pkg::JC) ||
                 (op == ice51_pkg::JNC);
      if (op == ice51_pkg::MOV_DPTR_IMM)
         instr_len = 2'd3;
      else if (two_byte)
         instr_len = 2'd2;
      else
         instr_len = 2'd1;
   endfunction

   ////////////////////////////////////////
   // sequencer

   // pc steps once per byte read, so it already points past the instruction
   always_comb begin
      state_nxt = state;
      pc_inc    = 1'b0;
      case (state)
         ice51_pkg::ST_FETCH: if (i_run) begin
            state_nxt = ice51_pkg::ST_OPCODE;
            pc_inc    = 1'b1;
         end
         ice51_pkg::ST_OPCODE: begin
            pc_inc    = (instr_len(i_code_data) != 2'd1);
            state_nxt = pc_inc ? ice51_pkg::ST_OPERAND1 : ice51_pkg::ST_EXECUTE;
         end
         ice51_pkg::ST_OPERAND1: begin
            pc_inc    = (op_q == ice51_pkg::MOV_DPTR_IMM);
            state_nxt = pc_inc ? ice51_pkg::ST_OPERAND2 : ice51_pkg::ST_EXECUTE;
         end
         ice51_pkg::ST_OPERAND2: state_nxt = ice51_pkg::ST_EXECUTE;
         default: state_nxt = ice51_pkg::ST_FETCH;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst)
         state <= ice51_pkg::ST_FETCH;
      else
         state <= state_nxt;
   end

   // opcode and operand latches
   always_ff @(posedge i_clk) begin
      if (state == ice51_pkg::ST_OPCODE)
         op_q <= i_code_data;
      if (state == ice51_pkg::ST_OPERAND1)
         opnd1_q <= i_code_data;
      if (state == ice51_pkg::ST_OPERAND2)
         opnd2_q <= i_code_data;
   end

   ////////////////////////////////////////
   // program counter

   always_comb begin
      case (op_q)
         ice51_pkg::SJMP: br_take = 1'b1;
         ice51_pkg::JZ:   br_take = i_flags.acc_zero;
         ice51_pkg::JNZ:  br_take = !i_flags.acc_zero;
         ice51_pkg::JC:   br_take = i_flags.carry;
         ice51_pkg::JNC:  br_take = !i_flags.carry;
         default:         br_take = 1'b0;
      endcase
   end

   assign br_off = {opnd1_q[7], opnd1_q};  // sign extend, 9 bit wrap

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst)
         pc <= '0;
      else if (pc_inc)
         pc <= pc + 1'b1;
      else if (state == ice51_pkg::ST_EXECUTE && br_take)
         pc <= pc + br_off;
   end

   assign o_core_req.wr   = 1'b0;  // core only reads code
   assign o_core_req.addr = pc;
   assign o_core_req.data = '0;

   ////////////////////////////////////////
   // execute and data port

   assign o_cmd.exec    = (state == ice51_pkg::ST_EXECUTE);
   assign o_cmd.opcode  = op_q;
   assign o_cmd.opnd1   = opnd1_q;
   assign o_cmd.opnd2   = opnd2_q;
   assign o_cmd.data_rd = i_data_data;   // read issued in operand1

   assign o_data_wr   = o_cmd.exec && (op_q == ice51_pkg::MOV_DIR_A);
   assign o_data_addr = (state == ice51_pkg::ST_OPERAND1) ?
                        ice51_pkg::data_addr_t'(i_code_data) :
                        ice51_pkg::data_addr_t'(opnd1_q);
   assign o_data_data = i_flags.acc;

endmodule

/* hw/code_port_arbiter.sv */
`timescale 1ns/1ps

module code_port_arbiter (
   input  logic                  i_clk,
   input  logic                  i_nrst,
   input  logic                  i_rx_valid,
   input  ice51_pkg::byte_t      i_rx_byte,
   input  ice51_pkg::code_req_t  i_core_req,
   output logic                  o_code_wr,
   output ice51_pkg::code_addr_t o_code_addr,
   output ice51_pkg::byte_t      o_code_data,
   output logic                  o_run
);

   ice51_pkg::grant_e     grant;
   ice51_pkg::code_addr_t load_addr;
   logic                  load_last;

   assign load_last = i_rx_valid &&
                      (load_addr == ice51_pkg::code_addr_t'(ice51_pkg::CODE_DEPTH - 1));

   // grant only ever moves from loader to core
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         grant     <= ice51_pkg::GRANT_LOADER;
         load_addr <= '0;
      end else if (grant == ice51_pkg::GRANT_LOADER) begin
         if (i_rx_valid)
            load_addr <= load_addr + 1'b1;
         if (load_last)
            grant <= ice51_pkg::GRANT_CORE;
      end
   end

   assign o_run       = (grant == ice51_pkg::GRANT_CORE);
   assign o_code_wr   = o_run ? i_core_req.wr   : i_rx_valid;
   assign o_code_addr = o_run ? i_core_req.addr : load_addr;
   assign o_code_data = o_run ? i_core_req.data : i_rx_byte;

endmodule

/* hw/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx (
   input  logic             i_clk,
   input  logic             i_nrst,
   input  logic             i_tx_start,
   input  ice51_pkg::byte_t i_tx_byte,
   output logic             o_uart_tx,
   output logic             o_tx_busy
);

   typedef enum logic [1:0] {TX_IDLE, TX_START, TX_SEND} tx_state_e;

   tx_state_e            state;
   ice51_pkg::baud_cnt_t cnt;
   logic [3:0]           bit_cnt;
   logic [8:0]           shift;   // data plus start bit
   logic                 tick;

   assign tick = (cnt == ice51_pkg::baud_cnt_t'(ice51_pkg::UART_SAMPLE));

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state   <= TX_IDLE;
         cnt     <= '0;
         bit_cnt <= '0;
      end else begin
         cnt <= tick ? '0 : cnt + 1'b1;
         case (state)
            TX_IDLE: begin
               cnt     <= '0;
               bit_cnt <= '0;
               if (i_tx_start)
                  state <= TX_START;
            end
            TX_START: if (tick)
               state <= TX_SEND;  // one idle bit before the frame
            default: if (tick) begin
               bit_cnt <= bit_cnt + 1'b1;
               if (bit_cnt == 4'd9)
                  state <= TX_IDLE;  // stop bit done
            end
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (state == TX_IDLE && i_tx_start)
         shift <= {i_tx_byte, 1'b0};
      else if (state == TX_SEND && tick)
         shift <= {1'b1, shift[8:1]};  // ones fill in, last one is the stop bit
   end

   assign o_uart_tx = (state == TX_SEND) ? shift[0] : 1'b1;
   assign o_tx_busy = (state != TX_IDLE);

endmodule

/* hw/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx (
   input  logic             i_clk,
   input  logic             i_nrst,
   input  logic             i_uart_rx,
   output logic             o_rx_valid,
   output ice51_pkg::byte_t o_rx_byte
);

   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

   logic                 rx_meta;
   logic                 rx_sync;
   rx_state_e            state;
   ice51_pkg::baud_cnt_t cnt;
   ice51_pkg::byte_t     shift;
   logic                 full_tick;
   logic                 half_tick;

   // two flop resync of the line
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
      end else begin
         rx_meta <= i_uart_rx;
         rx_sync <= rx_meta;
      end
   end

   assign full_tick = (cnt == ice51_pkg::baud_cnt_t'(ice51_pkg::UART_SAMPLE));
   assign half_tick = (cnt == ice51_pkg::baud_cnt_t'(ice51_pkg::UART_SAMPLE >> 1));

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state <= RX_IDLE;
         cnt   <= '0;
      end else begin
         cnt <= cnt + 1'b1;
         case (state)
            RX_IDLE: begin
               cnt <= '0;
               if (!rx_sync)
                  state <= RX_START;
            end
            RX_START: if (half_tick) begin
               cnt   <= '0;
               state <= rx_sync ? RX_IDLE : RX_DATA;  // glitch goes back to idle
            end
            RX_DATA: if (full_tick) begin
               cnt <= '0;
               if (shift[0])
                  state <= RX_STOP;  // marker reached the bottom
            end
            default: if (full_tick)
               state <= RX_IDLE;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (state == RX_IDLE)
         shift <= 8'h80;                          // marker bit
      else if (state == RX_DATA && full_tick)
         shift <= {rx_sync, shift[7:1]};          // lsb first
   end

   assign o_rx_valid = (state == RX_STOP) && full_tick;  // mid stop bit
   assign o_rx_byte  = shift;

endmodule

/* hw/ice51_pkg.sv */
package ice51_pkg;

   ////////////////////////////////////////
   // widths

   typedef logic [7:0]  byte_t;       // one byte on any port
   typedef logic [8:0]  code_addr_t;  // code address and pc
   typedef logic [8:0]  data_addr_t;
   typedef logic [15:0] dptr_t;
   typedef logic [2:0]  reg_idx_t;    // r0..r7

   localparam int CODE_DEPTH  = 512;  // bytes taken by the loader
   localparam int UART_SAMPLE = 104;  // bit period is UART_SAMPLE+1 clocks
   localparam int UART_CNT_W  = $clog2(UART_SAMPLE + 1);

   typedef logic [UART_CNT_W-1:0] baud_cnt_t;

   ////////////////////////////////////////
   // opcodes

   // register forms carry rn in the low three bits
   localparam byte_t MOV_A_IMM    = 8'h74;
   localparam byte_t MOV_RN_IMM   = 8'h78;
   localparam byte_t MOV_A_RN     = 8'hE8;
   localparam byte_t MOV_RN_A     = 8'hF8;
   localparam byte_t MOV_A_DIR    = 8'hE5;
   localparam byte_t MOV_DIR_A    = 8'hF5;
   localparam byte_t MOV_DPTR_IMM = 8'h90;  // high byte comes first
   localparam byte_t ADD_A_IMM    = 8'h24;
   localparam byte_t ADD_A_RN     = 8'h28;
   localparam byte_t INC_A        = 8'h04;
   localparam byte_t DEC_RN       = 8'h18;
   localparam byte_t CLR_C        = 8'hC3;
   localparam byte_t SJMP         = 8'h80;
   localparam byte_t JZ           = 8'h60;
   localparam byte_t JNZ          = 8'h70;
   localparam byte_t JC           = 8'h40;
   localparam byte_t JNC          = 8'h50;
   localparam byte_t MOVX_A_DPTR  = 8'hE0;
   localparam byte_t MOVX_DPTR_A  = 8'hF0;

   // movx targets
   localparam dptr_t UART_TX_ADDR   = 16'h0201;
   localparam dptr_t UART_STAT_ADDR = 16'h0200;

   ////////////////////////////////////////
   // states and bundles

   typedef enum logic [2:0] {
      ST_FETCH,
      ST_OPCODE,
      ST_OPERAND1,
      ST_OPERAND2,
      ST_EXECUTE
   } cpu_state_e;

   typedef enum logic {
      GRANT_LOADER,
      GRANT_CORE
   } grant_e;

   typedef struct packed {
      logic  exec;     // one cycle per instruction
      byte_t opcode;
      byte_t opnd1;
      byte_t opnd2;
      byte_t data_rd;  // data memory read byte
   } exec_cmd_t;

   typedef struct packed {
      logic  acc_zero;
      logic  carry;
      byte_t acc;
   } core_flags_t;

   typedef struct packed {
      logic       wr;
      code_addr_t addr;
      byte_t      data;
   } code_req_t;

endpackage
